/* files.f */
pwmPkg.sv
pwmRegs.sv
pwmTimer.sv
pwmSampleFifo.sv
pwmOutput.sv
pwmSound.sv
tb_pwmSound.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f files.f --top-module tb_pwmSound -o Vtb_pwmSound

run: build
	./obj_dir/Vtb_pwmSound | tee sim.log
	grep -q "^sim passed$$" sim.log

lint:
	verilator --lint-only --timing -f files.f --top-module tb_pwmSound

clean:
	rm -rf obj_dir sim.log

/* tb_pwmSound.sv */
`timescale 1ns/1ns

module tb_pwmSound import pwmPkg::*; ();

	typedef enum logic [2:0] {
		OP_WRITE, OP_READ, OP_WAIT_LEFT, OP_WAIT_RIGHT, OP_WAIT_BOTH, OP_IRQ, OP_DREQ
	} stepOp_t;

	typedef struct packed {
		stepOp_t    op;
		regAddr_t   addr;
		regWord_t   data;
		logic [1:0] lanes;   // {hi, lo}
		regWord_t   expVal;
	} step_t;

	logic CLK;
	logic RST_N;
	logic tickEn;
	cpuBus_t bus;
	regWord_t rdData;
	audioSample_t pwmLeft;
	audioSample_t pwmRight;
	logic pwmIrq;
	logic pwmDreq;

	step_t steps[$];
	logic [31:0] lfsr = 32'h935a;
	audioSample_t lastLeft;
	audioSample_t lastRight;
	logic tableReady = 1'b0;
	logic dreqLast = 1'b0;
	int dreqPulses = 0;

	pwmSound i_dut (.CLK(CLK), .RST_N(RST_N), .tickEn(tickEn), .bus(bus), .rdData(rdData),
		.pwmLeft(pwmLeft), .pwmRight(pwmRight), .pwmIrq(pwmIrq), .pwmDreq(pwmDreq));

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	task automatic failNow(input string what, input regWord_t got, input regWord_t exp);
		$display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
		$display("sim failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic int randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsrStep(lfsr);
		end
		return int'(r);
	endfunction

	// Centred width scaled by 32 for short cycles, by 16 otherwise
	function automatic audioSample_t expectSample(input pulseWidth_t w, input pulseWidth_t cyc);
		int c;
		if (w == '0) c = 0;
		else if (w > cyc) c = int'(cyc) / 2;
		else c = int'(w) - int'(cyc) / 2;
		return (cyc < 12'd2048) ? audioSample_t'(c * 32) : audioSample_t'(c * 16);
	endfunction

	// Consecutive samples must differ so each update is visible
	function automatic pulseWidth_t pickWidth(input pulseWidth_t cyc,
			input audioSample_t avoidA, input audioSample_t avoidB);
		int w;
		w = randBits(12) % int'(cyc) + 1;
		while (expectSample(pulseWidth_t'(w), cyc) == avoidA ||
				expectSample(pulseWidth_t'(w), cyc) == avoidB)
			w = w % int'(cyc) + 1;
		return pulseWidth_t'(w);
	endfunction

	function automatic void addStep(input stepOp_t op, input regAddr_t a, input regWord_t d,
			input logic [1:0] lanes, input regWord_t exp);
		steps.push_back('{op: op, addr: a, data: d, lanes: lanes, expVal: exp});
	endfunction

	function automatic void addWrite(input regAddr_t a, input regWord_t d, input logic [1:0] lanes);
		addStep(OP_WRITE, a, d, lanes, '0);
	endfunction

	function automatic void addCheck(input stepOp_t op, input regAddr_t a, input regWord_t exp);
		addStep(op, a, '0, 2'b00, exp);
	endfunction

	function automatic void runLeft(input pulseWidth_t cyc, input pulseWidth_t ws[$]);
		foreach (ws[i]) addWrite(ADDR_LEFT, {4'h0, ws[i]}, 2'b11);
		addWrite(ADDR_CTRL, 16'h0003, 2'b11);
		foreach (ws[i]) begin
			lastLeft = expectSample(ws[i], cyc);
			addCheck(OP_WAIT_LEFT, ADDR_CTRL, lastLeft);
		end
		addWrite(ADDR_CTRL, 16'h0000, 2'b11);
	endfunction

	// Pushes n right widths, enables with ctrlVal, waits for them on the chosen outputs
	function automatic void runRight(input int n, input regWord_t ctrlVal, input stepOp_t waitOp);
		pulseWidth_t ws[$];
		audioSample_t prev;
		prev = lastRight;
		for (int i = 0; i < n; i++) begin
			ws.push_back(pickWidth(12'd100, prev, lastLeft));
			prev = expectSample(ws[i], 12'd100);
			addWrite(ADDR_RIGHT, {4'h0, ws[i]}, 2'b11);
		end
		addWrite(ADDR_CTRL, ctrlVal, 2'b11);
		foreach (ws[i]) begin
			lastRight = expectSample(ws[i], 12'd100);
			if (waitOp == OP_WAIT_BOTH) lastLeft = lastRight;
			addCheck(waitOp, ADDR_CTRL, lastRight);
		end
	endfunction

	function automatic void buildTable();
		pulseWidth_t cycles[2] = '{12'd100, 12'd2500};
		pulseWidth_t w;
		step_t drain[$];
		lastLeft = '0;
		lastRight = '0;
		addCheck(OP_READ, ADDR_LEFT, 16'h4000);
		addCheck(OP_IRQ, ADDR_CTRL, 16'h0000);
		addWrite(ADDR_CTRL, 16'hFFFF, 2'b11);
		addCheck(OP_READ, ADDR_CTRL, 16'h0F8F);   // Reserved bits stay zero
		addWrite(ADDR_CTRL, 16'h0000, 2'b01);
		addCheck(OP_READ, ADDR_CTRL, 16'h0F00);
		addWrite(ADDR_CYCLE, 16'hFFFF, 2'b11);
		addCheck(OP_READ, ADDR_CYCLE, 16'h0FFF);
		addWrite(ADDR_CYCLE, 16'h1234, 2'b01);
		addCheck(OP_READ, ADDR_CYCLE, 16'h0F34);
		addWrite(ADDR_CTRL, 16'h0000, 2'b11);
		addWrite(ADDR_CYCLE, 16'd100, 2'b11);

		// FIFO fill, overflow push, drain in order
		addCheck(OP_READ, ADDR_RIGHT, 16'h4000);
		runRight(3, 16'h0000, OP_WAIT_RIGHT);
		for (int i = 0; i < 3; i++) drain.push_front(steps.pop_back());   // Waits go after full checks
		addCheck(OP_READ, ADDR_RIGHT, 16'h8000);
		addWrite(ADDR_RIGHT, 16'h0055, 2'b11);    // Ignored
		addCheck(OP_READ, ADDR_MONO, 16'h8000);
		addWrite(ADDR_CTRL, 16'h0003, 2'b11);
		foreach (drain[i]) steps.push_back(drain[i]);
		addCheck(OP_READ, ADDR_RIGHT, 16'h4000);
		addWrite(ADDR_CTRL, 16'h0000, 2'b11);

		foreach (cycles[c]) begin
			addWrite(ADDR_CYCLE, {4'h0, cycles[c]}, 2'b11);
			w = pickWidth(cycles[c], lastLeft, 16'h0000);
			runLeft(cycles[c], '{w, 12'h000, pulseWidth_t'(cycles[c] + 12'd7)});
			w = pickWidth(cycles[c], lastLeft, lastLeft);
			runLeft(cycles[c], '{w, pickWidth(cycles[c], expectSample(w, cycles[c]), lastLeft)});
		end

		addWrite(ADDR_CYCLE, 16'd100, 2'b11);
		runRight(3, 16'h0007, OP_WAIT_BOTH);      // Mono
		addWrite(ADDR_CTRL, 16'h0000, 2'b11);

		addCheck(OP_DREQ, ADDR_CTRL, 16'd0);
		runRight(2, 16'h028B, OP_WAIT_RIGHT);
		steps.insert(steps.size() - 1, '{OP_IRQ, ADDR_CTRL, 16'h0, 2'b00, 16'h0});
		addCheck(OP_IRQ, ADDR_CTRL, 16'h0001);
		addCheck(OP_DREQ, ADDR_CTRL, 16'd1);
		addWrite(ADDR_IRQCLR, 16'h0000, 2'b11);
		addCheck(OP_IRQ, ADDR_CTRL, 16'h0000);
		runRight(2, 16'h0203, OP_WAIT_RIGHT);    // Interrupt disabled
		addCheck(OP_IRQ, ADDR_CTRL, 16'h0000);
		addCheck(OP_DREQ, ADDR_CTRL, 16'd1);
	endfunction

	task automatic applyStep(input step_t s);
		audioSample_t prevL;
		audioSample_t prevR;
		case (s.op)
			OP_WRITE, OP_READ: begin
				@(posedge CLK);
				bus <= '{addr: s.addr, data: s.data, wrLo: s.lanes[0], wrHi: s.lanes[1],
					wrEn: (s.op == OP_WRITE), rdEn: (s.op == OP_READ)};
				@(posedge CLK);
				bus <= '0;
				if (s.op == OP_READ) begin
					@(negedge CLK);
					assert (rdData == s.expVal) else failNow("register read", rdData, s.expVal);
				end
			end
			OP_WAIT_LEFT, OP_WAIT_RIGHT, OP_WAIT_BOTH: begin
				@(negedge CLK);
				prevL = pwmLeft;
				prevR = pwmRight;
				do @(negedge CLK);
				while ((s.op == OP_WAIT_RIGHT || pwmLeft == prevL) &&
					(s.op == OP_WAIT_LEFT || pwmRight == prevR));
				if (s.op != OP_WAIT_RIGHT)
					assert (pwmLeft == s.expVal) else failNow("pwmLeft", pwmLeft, s.expVal);
				if (s.op != OP_WAIT_LEFT)
					assert (pwmRight == s.expVal) else failNow("pwmRight", pwmRight, s.expVal);
			end
			OP_IRQ: begin
				@(negedge CLK);
				assert (pwmIrq == s.expVal[0]) else failNow("pwmIrq", 16'(pwmIrq), s.expVal);
			end
			default: begin
				assert (dreqPulses == int'(s.expVal))
				else failNow("pwmDreq pulse count", 16'(dreqPulses), s.expVal);
			end
		endcase
	endtask

	always @(negedge CLK) begin
		if (pwmDreq) begin
			assert (!dreqLast) else failNow("pwmDreq width", 16'h2, 16'h1);
			dreqPulses = dreqPulses + 1;
		end
		dreqLast = pwmDreq;
	end

	initial begin
		longint limit;
		wait (tableReady);
		limit = longint'(steps.size()) * 4095 * 4 * 10;
		#(limit);
		$display("Timeout: the test table did not complete in %0d ns", limit);
		$display("sim failed");
		$fatal(1);
	end

	initial begin
		bus <= '0;
		tickEn <= 1'b0;
		RST_N <= 1'b0;
		buildTable();
		tableReady = 1'b1;
		repeat (4) @(posedge CLK);
		RST_N <= 1'b1;
		tickEn <= 1'b1;   // Every clock is a PWM tick
		foreach (steps[i]) applyStep(steps[i]);
		$display("sim passed");
		$finish;
	end

endmodule

/* pwmSound.sv */
`timescale 1ns/1ns

module pwmSound import pwmPkg::*; (
	input  logic         CLK,
	input  logic         RST_N,
	input  logic         tickEn,
	input  cpuBus_t      bus,
	output regWord_t     rdData,
	output audioSample_t pwmLeft,
	output audioSample_t pwmRight,
	output logic         pwmIrq,
	output logic         pwmDreq
);

	pwmCtrl_t ctrl;
	pulseWidth_t cycle;
	logic restart;
	logic irqClear;
	logic pushLeft;
	logic pushRight;
	pulseWidth_t pushData;
	logic sampleTick;
	pulseWidth_t leftPopData;
	pulseWidth_t rightPopData;
	logic leftPopValid;
	logic rightPopValid;
	logic leftFull;
	logic leftEmpty;
	logic rightFull;
	logic rightEmpty;

	pwmRegs regs (
		.CLK(CLK), .RST_N(RST_N), .bus(bus), .rdData(rdData),
		.ctrl(ctrl), .cycle(cycle), .restart(restart), .irqClear(irqClear),
		.pushLeft(pushLeft), .pushRight(pushRight), .pushData(pushData),
		.leftFull(leftFull), .leftEmpty(leftEmpty),
		.rightFull(rightFull), .rightEmpty(rightEmpty)
	);

	pwmTimer timer (
		.CLK(CLK), .RST_N(RST_N), .tickEn(tickEn), .ctrl(ctrl), .cycle(cycle),
		.restart(restart), .irqClear(irqClear), .sampleTick(sampleTick),
		.pwmIrq(pwmIrq), .pwmDreq(pwmDreq)
	);

	// Both channels pop on the same sample tick
	pwmSampleFifo leftFifo (
		.CLK(CLK), .RST_N(RST_N), .push(pushLeft), .pushData(pushData),
		.pop(sampleTick), .popData(leftPopData), .popValid(leftPopValid),
		.full(leftFull), .empty(leftEmpty)
	);

	pwmSampleFifo rightFifo (
		.CLK(CLK), .RST_N(RST_N), .push(pushRight), .pushData(pushData),
		.pop(sampleTick), .popData(rightPopData), .popValid(rightPopValid),
		.full(rightFull), .empty(rightEmpty)
	);

	pwmOutput outStage (
		.CLK(CLK), .RST_N(RST_N), .mono(ctrl.mono), .cycle(cycle),
		.leftData(leftPopData), .rightData(rightPopData),
		.leftValid(leftPopValid), .rightValid(rightPopValid),
		.pwmLeft(pwmLeft), .pwmRight(pwmRight)
	);

endmodule

/* pwmOutput.sv */
`timescale 1ns/1ns

module pwmOutput import pwmPkg::*; (
	input  logic         CLK,
	input  logic         RST_N,
	input  logic         mono,
	input  pulseWidth_t  cycle,
	input  pulseWidth_t  leftData,
	input  pulseWidth_t  rightData,
	input  logic         leftValid,
	input  logic         rightValid,
	output audioSample_t pwmLeft,
	output audioSample_t pwmRight
);

	pulseWidth_t leftSrc;
	logic leftSrcValid;

	// Centre the width around half a cycle, clamping overlong widths
	function automatic pulseWidth_t centre(input pulseWidth_t width, input pulseWidth_t cyc);
		pulseWidth_t half;
		half = cyc >> 1;
		if (width == '0) return '0;
		if (width > cyc) return half;
		return width - half;
	endfunction

	// Short cycles get more gain
	function automatic audioSample_t scale(input pulseWidth_t value, input pulseWidth_t cyc);
		if (!cyc[11]) return {value[11], value[9:0], 5'b00000};
		return {value, 4'b0000};
	endfunction

	assign leftSrc = mono ? rightData : leftData;
	assign leftSrcValid = mono ? rightValid : leftValid;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pwmLeft <= '0;
			pwmRight <= '0;
		end else begin
			if (leftSrcValid) pwmLeft <= scale(centre(leftSrc, cycle), cycle);
			if (rightValid) pwmRight <= scale(centre(rightData, cycle), cycle);
		end
	end

endmodule

/* pwmSampleFifo.sv */
`timescale 1ns/1ns

module pwmSampleFifo import pwmPkg::*; (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        push,
	input  pulseWidth_t pushData,
	input  logic        pop,
	output pulseWidth_t popData,
	output logic        popValid,
	output logic        full,
	output logic        empty
);

	pulseWidth_t mem [FIFO_DEPTH];
	fifoPtr_t wrPtr;
	fifoPtr_t rdPtr;
	fifoCount_t count;
	logic doPush;
	logic doPop;

	function automatic fifoPtr_t nextPtr(input fifoPtr_t ptr);
		return (ptr == fifoPtr_t'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full = (count == fifoCount_t'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign doPush = push && !full;     // Dropped when full
	assign doPop = pop && !empty;

	always_ff @(posedge CLK) begin
		if (doPush) mem[wrPtr] <= pushData;
		if (doPop) popData <= mem[rdPtr];
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			popValid <= 1'b0;
		end else begin
			popValid <= doPop;
			if (doPush) wrPtr <= nextPtr(wrPtr);
			if (doPop) rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;      // Both or neither
			endcase
		end
	end

endmodule

/* pwmTimer.sv */
`timescale 1ns/1ns

module pwmTimer import pwmPkg::*; (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        tickEn,
	input  pwmCtrl_t    ctrl,
	input  pulseWidth_t cycle,
	input  logic        restart,
	input  logic        irqClear,
	output logic        sampleTick,
	output logic        pwmIrq,
	output logic        pwmDreq
);

	pulseWidth_t periodCnt;
	pulseWidth_t periodNext;
	timerCount_t intervalCnt;
	timerCount_t intervalNext;
	timerCount_t intervalLimit;
	logic running;
	logic intervalDone;

	assign running = (cycle != '0) && (ctrl.leftEn || ctrl.rightEn);
	assign periodNext = periodCnt + 1'b1;

	// Fires on the enabled tick that completes the period
	assign sampleTick = running && tickEn && !restart && (periodNext == cycle);

	assign intervalLimit = (ctrl.interval == '0) ? timerCount_t'(1) : ctrl.interval;
	assign intervalNext = intervalCnt + 1'b1;
	assign intervalDone = sampleTick && (intervalNext == intervalLimit);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			periodCnt <= '0;
			intervalCnt <= '0;
			pwmIrq <= 1'b0;
			pwmDreq <= 1'b0;
		end else begin
			pwmDreq <= 1'b0;
			if (restart || !running) begin
				periodCnt <= '0;
				intervalCnt <= '0;
			end else if (sampleTick) begin
				periodCnt <= '0;
				intervalCnt <= intervalDone ? '0 : intervalNext;
			end else if (tickEn) begin
				periodCnt <= periodNext;
			end

			if (irqClear) pwmIrq <= 1'b0;
			if (intervalDone) begin
				if (ctrl.irqEn) pwmIrq <= 1'b1;    // Sticky until cleared
				pwmDreq <= ctrl.dreqEn;
			end
		end
	end

endmodule

/* pwmRegs.sv */
`timescale 1ns/1ns

module pwmRegs import pwmPkg::*; (
	input  logic        CLK,
	input  logic        RST_N,
	input  cpuBus_t     bus,
	output regWord_t    rdData,
	output pwmCtrl_t    ctrl,
	output pulseWidth_t cycle,
	output logic        restart,
	output logic        irqClear,
	output logic        pushLeft,
	output logic        pushRight,
	output pulseWidth_t pushData,
	input  logic        leftFull,
	input  logic        leftEmpty,
	input  logic        rightFull,
	input  logic        rightEmpty
);

	logic laneWrite;
	logic [7:0] hiLane;
	logic [7:0] loLane;

	assign laneWrite = bus.wrEn && (bus.wrLo || bus.wrHi);

	// Timer restarts on any control or cycle write
	assign restart = bus.wrEn && (bus.addr == ADDR_CTRL || bus.addr == ADDR_CYCLE);
	assign irqClear = bus.wrEn && (bus.addr == ADDR_IRQCLR);

	assign pushLeft = laneWrite && (bus.addr == ADDR_LEFT || bus.addr == ADDR_MONO);
	assign pushRight = laneWrite && (bus.addr == ADDR_RIGHT || bus.addr == ADDR_MONO);

	// Unwritten lanes push as zero
	assign hiLane = bus.wrHi ? bus.data[15:8] : 8'h00;
	assign loLane = bus.wrLo ? bus.data[7:0] : 8'h00;
	assign pushData = {hiLane[3:0], loLane};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ctrl <= '0;
			cycle <= '0;
		end else if (bus.wrEn) begin
			if (bus.addr == ADDR_CTRL) begin
				if (bus.wrLo) ctrl[7:0] <= bus.data[7:0] & CTRL_MASK[7:0];
				if (bus.wrHi) ctrl[15:8] <= bus.data[15:8] & CTRL_MASK[15:8];
			end
			if (bus.addr == ADDR_CYCLE) begin
				if (bus.wrLo) cycle[7:0] <= bus.data[7:0];
				if (bus.wrHi) cycle[11:8] <= bus.data[11:8];
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rdData <= '0;
		end else if (bus.rdEn) begin
			case (bus.addr)
				ADDR_CTRL: begin
					rdData <= ctrl;
				end
				ADDR_CYCLE: begin
					rdData <= {4'h0, cycle};
				end
				ADDR_LEFT: begin
					rdData <= {leftFull, leftEmpty, 14'h0000};
				end
				ADDR_RIGHT, ADDR_MONO: begin   // Mono reports the right side
					rdData <= {rightFull, rightEmpty, 14'h0000};
				end
				default: begin
					rdData <= '0;
				end
			endcase
		end
	end

endmodule

/* pwmPkg.sv */
package pwmPkg;

	typedef logic [11:0] pulseWidth_t;     // Width or cycle length in PWM ticks
	typedef logic [15:0] audioSample_t;    // Signed audio out
	typedef logic [15:0] regWord_t;
	typedef logic [2:0]  regAddr_t;        // Word offset in the register block
	typedef logic [3:0]  timerCount_t;     // Sample periods per interrupt

	localparam int FIFO_DEPTH = 3;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

	typedef logic [FIFO_PTR_W-1:0] fifoPtr_t;
	typedef logic [FIFO_CNT_W-1:0] fifoCount_t;

	localparam regAddr_t ADDR_CTRL   = 3'd0;
	localparam regAddr_t ADDR_CYCLE  = 3'd1;
	localparam regAddr_t ADDR_LEFT   = 3'd2;
	localparam regAddr_t ADDR_RIGHT  = 3'd3;
	localparam regAddr_t ADDR_MONO   = 3'd4;   // Pushes both channels
	localparam regAddr_t ADDR_IRQCLR = 3'd5;

	// Writable bits of the control register
	localparam regWord_t CTRL_MASK = 16'h0F8F;

	typedef struct packed {
		logic [3:0]  reservedHi;
		timerCount_t interval;   // 0 behaves as 1
		logic        dreqEn;
		logic [2:0]  reservedLo;
		logic        irqEn;
		logic        mono;
		logic        rightEn;
		logic        leftEn;
	} pwmCtrl_t;

	// One CPU access, strobes last a single cycle
	typedef struct packed {
		regAddr_t addr;
		regWord_t data;
		logic     wrLo;
		logic     wrHi;
		logic     wrEn;
		logic     rdEn;
	} cpuBus_t;

endpackage
